// File: Bender.yml
package:
  name: bt_uart_bridge

sources:
  - hdl/bt_pkg.sv
  - hdl/byte_fifo.sv
  - hdl/uart_tx.sv
  - hdl/uart_rx.sv
  - hdl/request_sender.sv
  - hdl/response_framer.sv
  - hdl/bt_uart_bridge.sv
  - target: test
    files:
      - tb/tb_bt_uart_bridge.sv

// File: build.f
hdl/bt_pkg.sv
hdl/byte_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/request_sender.sv
hdl/response_framer.sv
hdl/bt_uart_bridge.sv
tb/tb_bt_uart_bridge.sv

// File: hdl/bt_pkg.sv
`default_nettype none

package bt_pkg;

	// serial link, fixed 8N1
	localparam int BYTE_W = 8;
	localparam int CLK_FREQ_HZ = 1843200;
	localparam int BAUD_RATE = 115200;
	localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT + 1);

	// 32 entries per FIFO
	localparam int FIFO_DEPTH_LOG2 = 5;

	// stream markers from the module
	localparam logic [BYTE_W-1:0] SYNC_HEAD = 8'h55;
	localparam logic [BYTE_W-1:0] SYNC_FUNC = 8'h50;

	// request sender states
	localparam logic [1:0] SND_IDLE = 2'd0;
	localparam logic [1:0] SND_READ = 2'd1;
	localparam logic [1:0] SND_LAUNCH = 2'd2;
	localparam logic [1:0] SND_WAIT = 2'd3;

	// one byte with its single-cycle strobe
	typedef struct packed {
		logic valid;
		logic [BYTE_W-1:0] data;
	} byte_strobe_t;

endpackage

`default_nettype wire

// File: hdl/bt_uart_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module bt_uart_bridge (
	input wire clk,
	input wire rst_n,
	input wire bt_pkg::byte_strobe_t req_i,
	output logic req_rdy_o,
	input wire resp_rd_i,
	output bt_pkg::byte_strobe_t resp_o,
	// serial from the module
	input wire bt_txd_i,
	// serial to the module
	output logic bt_rxd_o
);

	logic req_full;
	logic req_empty;
	logic req_rd;
	bt_pkg::byte_strobe_t req_data;
	bt_pkg::byte_strobe_t tx_start;
	logic tx_busy;
	bt_pkg::byte_strobe_t rx_byte;
	bt_pkg::byte_strobe_t resp_wr;
	logic resp_full;

	assign req_rdy_o = !req_full;

	// request path
	byte_fifo i_req_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_i      (req_i),
		.rd_i      (req_rd),
		.rd_data_o (req_data),
		.full_o    (req_full),
		.empty_o   (req_empty)
	);

	request_sender i_sender (
		.clk          (clk),
		.rst_n        (rst_n),
		.fifo_empty_i (req_empty),
		.fifo_rd_o    (req_rd),
		.fifo_data_i  (req_data),
		.tx_busy_i    (tx_busy),
		.tx_start_o   (tx_start)
	);

	uart_tx i_uart_tx (
		.clk       (clk),
		.rst_n     (rst_n),
		.start_i   (tx_start),
		.tx_busy_o (tx_busy),
		.txd_o     (bt_rxd_o)
	);

	// response path
	uart_rx i_uart_rx (
		.clk    (clk),
		.rst_n  (rst_n),
		.rxd_i  (bt_txd_i),
		.byte_o (rx_byte)
	);

	response_framer i_framer (
		.clk         (clk),
		.rst_n       (rst_n),
		.rx_byte_i   (rx_byte),
		.fifo_full_i (resp_full),
		.fifo_wr_o   (resp_wr)
	);

	byte_fifo i_resp_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_i      (resp_wr),
		.rd_i      (resp_rd_i),
		.rd_data_o (resp_o),
		.full_o    (resp_full),
		.empty_o   ()
	);

endmodule

`default_nettype wire

// File: hdl/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
	parameter int DEPTH_LOG2 = bt_pkg::FIFO_DEPTH_LOG2
) (
	input wire clk,
	input wire rst_n,
	input wire bt_pkg::byte_strobe_t wr_i,
	input wire rd_i,
	output bt_pkg::byte_strobe_t rd_data_o,
	output logic full_o,
	output logic empty_o
);

	localparam int DEPTH = 1 << DEPTH_LOG2;

	logic [bt_pkg::BYTE_W-1:0] mem [DEPTH];
	// extra msb tells a wrapped pointer from an equal one
	logic [DEPTH_LOG2:0] wr_ptr;
	logic [DEPTH_LOG2:0] rd_ptr;
	logic [DEPTH_LOG2:0] wr_ptr_nxt;
	logic [DEPTH_LOG2:0] rd_ptr_nxt;
	logic [DEPTH_LOG2:0] fill;
	logic do_wr;
	logic do_rd;
	logic rd_valid;
	logic [bt_pkg::BYTE_W-1:0] rd_data;

	assign do_wr = wr_i.valid && !full_o;
	assign do_rd = rd_i && !empty_o;
	assign wr_ptr_nxt = do_wr ? wr_ptr + 1'b1 : wr_ptr;
	assign rd_ptr_nxt = do_rd ? rd_ptr + 1'b1 : rd_ptr;
	assign fill = wr_ptr - rd_ptr;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			full_o <= 1'b0;
			empty_o <= 1'b1;
			rd_valid <= 1'b0;
		end
		else
		begin
			wr_ptr <= wr_ptr_nxt;
			rd_ptr <= rd_ptr_nxt;
			// flags follow the next pointers so they stay registered
			full_o <= (wr_ptr_nxt[DEPTH_LOG2] != rd_ptr_nxt[DEPTH_LOG2])
				&& (wr_ptr_nxt[DEPTH_LOG2-1:0] == rd_ptr_nxt[DEPTH_LOG2-1:0]);
			empty_o <= wr_ptr_nxt == rd_ptr_nxt;
			rd_valid <= do_rd;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr[DEPTH_LOG2-1:0]] <= wr_i.data;
		if (do_rd)
			rd_data <= mem[rd_ptr[DEPTH_LOG2-1:0]];
	end

	assign rd_data_o.valid = rd_valid;
	assign rd_data_o.data = rd_data;

	a_no_valid_from_empty: assert property (@(posedge clk) disable iff (!rst_n)
		rd_i && wr_ptr == rd_ptr |=> !rd_data_o.valid);

	// occupancy never exceeds the depth, so no pointer overtakes the other
	a_ptr_order: assert property (@(posedge clk) disable iff (!rst_n)
		fill <= DEPTH);

endmodule

`default_nettype wire

// File: hdl/request_sender.sv
`timescale 1ns/1ps
`default_nettype none

module request_sender (
	input wire clk,
	input wire rst_n,
	input wire fifo_empty_i,
	output logic fifo_rd_o,
	input wire bt_pkg::byte_strobe_t fifo_data_i,
	input wire tx_busy_i,
	output bt_pkg::byte_strobe_t tx_start_o
);

	logic [1:0] state;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= bt_pkg::SND_IDLE;
		else
		begin
			case (state)
				bt_pkg::SND_IDLE:
					if (!fifo_empty_i && !tx_busy_i)
						state <= bt_pkg::SND_READ;
				bt_pkg::SND_READ:
					state <= bt_pkg::SND_LAUNCH;
				// fifo data shows up one cycle after the read
				bt_pkg::SND_LAUNCH:
					state <= fifo_data_i.valid ? bt_pkg::SND_WAIT : bt_pkg::SND_IDLE;
				default:
					if (!tx_busy_i)
						state <= bt_pkg::SND_IDLE;
			endcase
		end
	end

	assign fifo_rd_o = state == bt_pkg::SND_READ;
	assign tx_start_o.valid = (state == bt_pkg::SND_LAUNCH) && fifo_data_i.valid;
	assign tx_start_o.data = fifo_data_i.data;

	// one byte in flight until the transmitter lets go
	a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
		tx_start_o.valid |=> !fifo_rd_o until !tx_busy_i);

endmodule

`default_nettype wire

// File: hdl/response_framer.sv
`timescale 1ns/1ps
`default_nettype none

module response_framer (
	input wire clk,
	input wire rst_n,
	input wire bt_pkg::byte_strobe_t rx_byte_i,
	input wire fifo_full_i,
	output bt_pkg::byte_strobe_t fifo_wr_o
);

	logic head_seen;
	logic func_seen;
	logic is_head;
	logic is_func;
	logic pass;
	logic wr_valid;
	logic [bt_pkg::BYTE_W-1:0] wr_data;

	assign is_head = !head_seen && rx_byte_i.data == bt_pkg::SYNC_HEAD;
	assign is_func = head_seen && !func_seen && rx_byte_i.data == bt_pkg::SYNC_FUNC;
	// markers are kept, and after both everything goes through
	assign pass = (head_seen && func_seen) || is_head || is_func;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			head_seen <= 1'b0;
			func_seen <= 1'b0;
			wr_valid <= 1'b0;
		end
		else
		begin
			// full fifo drops the byte, the line cannot wait
			wr_valid <= rx_byte_i.valid && pass && !fifo_full_i;
			if (rx_byte_i.valid && is_head)
				head_seen <= 1'b1;
			if (rx_byte_i.valid && is_func)
				func_seen <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rx_byte_i.valid)
			wr_data <= rx_byte_i.data;
	end

	assign fifo_wr_o.valid = wr_valid;
	assign fifo_wr_o.data = wr_data;

	a_func_after_head: assert property (@(posedge clk) disable iff (!rst_n)
		func_seen |-> head_seen);

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input wire clk,
	input wire rst_n,
	input wire rxd_i,
	output bt_pkg::byte_strobe_t byte_o
);

	logic rxd_meta;
	logic rxd_sync;
	logic active;
	logic [bt_pkg::BIT_CNT_W-1:0] clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_idx;
	logic [bt_pkg::BYTE_W-1:0] shreg;
	logic valid_q;
	logic at_half;
	logic at_full;
	logic sample;

	assign at_half = clk_cnt == bt_pkg::BIT_CNT_W'(bt_pkg::CLKS_PER_BIT / 2 - 1);
	assign at_full = clk_cnt == bt_pkg::BIT_CNT_W'(bt_pkg::CLKS_PER_BIT - 1);
	// start bit is checked at its middle, later bits one period on
	assign sample = active && ((bit_idx == 4'd0) ? at_half : at_full);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd_i;
			rxd_sync <= rxd_meta;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= 1'b0;
			if (!active)
			begin
				clk_cnt <= '0;
				bit_idx <= '0;
				if (!rxd_sync)
					active <= 1'b1;
			end
			else if (sample)
			begin
				clk_cnt <= '0;
				if (bit_idx == 4'd0)
				begin
					// glitch, not a real start bit
					if (rxd_sync)
						active <= 1'b0;
					else
						bit_idx <= 4'd1;
				end
				else if (bit_idx == 4'(bt_pkg::BYTE_W + 1))
				begin
					active <= 1'b0;
					valid_q <= rxd_sync;
				end
				else
					bit_idx <= bit_idx + 1'b1;
			end
			else
				clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// lsb first
	always_ff @(posedge clk)
	begin
		if (sample && bit_idx != 4'd0 && bit_idx <= 4'(bt_pkg::BYTE_W))
			shreg <= {rxd_sync, shreg[bt_pkg::BYTE_W-1:1]};
	end

	assign byte_o.valid = valid_q;
	assign byte_o.data = shreg;

	a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		byte_o.valid |=> !byte_o.valid);

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input wire clk,
	input wire rst_n,
	input wire bt_pkg::byte_strobe_t start_i,
	output logic tx_busy_o,
	output logic txd_o
);

	logic [bt_pkg::BIT_CNT_W-1:0] clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_idx;
	logic [bt_pkg::BYTE_W:0] shreg;
	logic bit_end;
	logic launch;

	assign bit_end = clk_cnt == bt_pkg::BIT_CNT_W'(bt_pkg::CLKS_PER_BIT - 1);
	assign launch = start_i.valid && !tx_busy_o;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			tx_busy_o <= 1'b0;
			txd_o <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= '0;
		end
		else if (launch)
		begin
			tx_busy_o <= 1'b1;
			txd_o <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
		end
		else if (tx_busy_o)
		begin
			if (bit_end)
			begin
				clk_cnt <= '0;
				if (bit_idx == 4'(bt_pkg::BYTE_W + 1))
					tx_busy_o <= 1'b0;
				else
				begin
					txd_o <= shreg[0];
					bit_idx <= bit_idx + 1'b1;
				end
			end
			else
				clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// stop bit rides in at the top of the shifter
	always_ff @(posedge clk)
	begin
		if (launch)
			shreg <= {1'b1, start_i.data};
		else if (tx_busy_o && bit_end)
			shreg <= shreg >> 1;
	end

	a_no_start_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		tx_busy_o |-> !start_i.valid);

endmodule

`default_nettype wire

// File: tb/tb_bt_uart_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bt_uart_bridge;

	localparam int CPB = bt_pkg::CLKS_PER_BIT;
	localparam int HOLD_LIMIT = 1000;
	localparam int DRAIN_LIMIT = 20000;

	logic clk;
	logic rst_n;
	bt_pkg::byte_strobe_t req;
	logic req_rdy;
	logic resp_rd;
	bt_pkg::byte_strobe_t resp;
	logic bt_txd;
	logic bt_rxd;

	integer seed;
	int check_errors;
	int timeouts;
	int resp_pending;
	logic head_seen;
	logic func_seen;
	logic saw_full;
	logic [7:0] req_exp[$];
	logic [7:0] resp_exp[$];

	bt_uart_bridge i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_i     (req),
		.req_rdy_o (req_rdy),
		.resp_rd_i (resp_rd),
		.resp_o    (resp),
		.bt_txd_i  (bt_txd),
		.bt_rxd_o  (bt_rxd)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic flag_error(input string msg);
		check_errors++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	// response side read timing
	a_resp_after_read: assert property (@(posedge clk) disable iff (!rst_n)
		resp.valid |-> $past(resp_rd))
		else flag_error("resp_o.valid without a read pulse");
	a_resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		resp.valid |=> !resp.valid)
		else flag_error("resp_o.valid held longer than one cycle");
	a_read_pending: assert property (@(posedge clk) disable iff (!rst_n)
		resp_rd && resp_pending > 0 |=> resp.valid)
		else flag_error("read with data pending gave no valid");
	a_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
		resp_rd && resp_pending == 0 |=> !resp.valid)
		else flag_error("read with nothing pending gave valid");

	// decodes bt_rxd_o and checks it against the request queue
	initial
	begin
		logic [7:0] rx_byte;
		int i;
		forever
		begin
			@(negedge clk);
			if (rst_n === 1'b1 && bt_rxd === 1'b0)
			begin
				repeat (CPB / 2) @(negedge clk);
				assert (bt_rxd === 1'b0)
					else flag_error("start bit on bt_rxd_o not low at mid-bit");
				for (i = 0; i < 8; i++)
				begin
					repeat (CPB) @(negedge clk);
					rx_byte[i] = bt_rxd;
				end
				repeat (CPB) @(negedge clk);
				assert (bt_rxd === 1'b1)
					else flag_error("stop bit on bt_rxd_o not high");
				if (req_exp.size() == 0)
					flag_error($sformatf("unexpected byte %02h on bt_rxd_o", rx_byte));
				else
				begin
					assert (rx_byte == req_exp[0])
						else flag_error($sformatf("sent %02h, expected %02h",
							rx_byte, req_exp[0]));
					void'(req_exp.pop_front());
				end
			end
		end
	end

	// holds the byte until req_rdy_o lets it in
	task automatic write_request(input logic [7:0] data);
		int waited;
		waited = 0;
		forever
		begin
			@(negedge clk);
			req.valid = 1'b1;
			req.data = data;
			if (req_rdy)
			begin
				req_exp.push_back(data);
				return;
			end
			saw_full = 1'b1;
			waited++;
			if (waited > HOLD_LIMIT)
			begin
				timeouts++;
				$display("timeout: req_rdy_o stayed low while holding a request byte");
				return;
			end
		end
	endtask

	task automatic stop_requests();
		@(negedge clk);
		req.valid = 1'b0;
	endtask

	task automatic wait_request_drain();
		int n;
		n = 0;
		while (req_exp.size() != 0 && n < DRAIN_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (req_exp.size() != 0)
		begin
			timeouts++;
			$display("timeout: request bytes were never transmitted");
		end
	endtask

	// 8N1 frame on bt_txd_i, lsb first
	task automatic send_serial(input logic [7:0] data);
		int i;
		@(negedge clk);
		bt_txd = 1'b0;
		for (i = 0; i < 8; i++)
		begin
			repeat (CPB) @(negedge clk);
			bt_txd = data[i];
		end
		repeat (CPB) @(negedge clk);
		bt_txd = 1'b1;
		repeat (CPB) @(negedge clk);
	endtask

	// expected response bytes from the head and function rule
	task automatic filter_model(input logic [7:0] data);
		if (head_seen && func_seen)
			resp_exp.push_back(data);
		else if (!head_seen && data == bt_pkg::SYNC_HEAD)
		begin
			resp_exp.push_back(data);
			head_seen = 1'b1;
		end
		else if (head_seen && !func_seen && data == bt_pkg::SYNC_FUNC)
		begin
			resp_exp.push_back(data);
			func_seen = 1'b1;
		end
	endtask

	task automatic stream_byte(input logic [7:0] data);
		filter_model(data);
		send_serial(data);
	endtask

	task automatic read_response(output logic got, output logic [7:0] data);
		@(negedge clk);
		resp_rd = 1'b1;
		@(negedge clk);
		resp_rd = 1'b0;
		got = resp.valid;
		data = resp.data;
	endtask

	initial
	begin
		logic [7:0] b;
		logic got;
		int i;
		int n;
		seed = 4978;
		check_errors = 0;
		timeouts = 0;
		resp_pending = 0;
		head_seen = 1'b0;
		func_seen = 1'b0;
		saw_full = 1'b0;
		rst_n = 1'b0;
		req = '0;
		resp_rd = 1'b0;
		bt_txd = 1'b1;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		@(negedge clk);
		assert (bt_rxd === 1'b1) else flag_error("bt_rxd_o not idle high after reset");
		assert (resp.valid === 1'b0) else flag_error("resp_o.valid high after reset");
		assert (req_rdy === 1'b1) else flag_error("req_rdy_o low after reset");
		read_response(got, b);

		// twenty random requests
		for (i = 0; i < 20; i++)
			write_request(8'($random(seed)));
		stop_requests();
		wait_request_drain();

		// forty back to back, more than the FIFO holds
		saw_full = 1'b0;
		for (i = 0; i < 40; i++)
			write_request(8'($random(seed)));
		stop_requests();
		assert (saw_full) else flag_error("req_rdy_o never went low under load");
		wait_request_drain();

		// noise, head, junk, function, payload
		for (i = 0; i < 4; i++)
		begin
			do
				b = 8'($random(seed));
			while (b == bt_pkg::SYNC_HEAD);
			stream_byte(b);
		end
		stream_byte(bt_pkg::SYNC_HEAD);
		do
			b = 8'($random(seed));
		while (b == bt_pkg::SYNC_FUNC);
		stream_byte(b);
		stream_byte(bt_pkg::SYNC_FUNC);
		for (i = 0; i < 6; i++)
			stream_byte(8'($random(seed)));

		resp_pending = resp_exp.size();
		n = 0;
		while (resp_exp.size() != 0 && n < 64)
		begin
			read_response(got, b);
			n++;
			if (got)
			begin
				assert (b == resp_exp[0])
					else flag_error($sformatf("read %02h, expected %02h", b, resp_exp[0]));
				void'(resp_exp.pop_front());
				resp_pending--;
			end
		end
		if (resp_exp.size() != 0)
		begin
			timeouts++;
			$display("timeout: response bytes never came out of the response FIFO");
		end
		read_response(got, b);
		assert (!got) else flag_error("extra byte in the response FIFO");

		$display("errors: %0d failed checks, %0d timeouts", check_errors, timeouts);
		if (check_errors == 0 && timeouts == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
